/* Makefile */
SIM      := verilator
TOP      := rename_unit_tb
FILELIST := rename_unit.f
SIMFLAGS := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
RUNFLAGS := +verilator+error+limit+1000
LOG      := sim.log

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "Verification passed" $(LOG); then echo "PASS"; \
	else echo "FAIL: no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/rename_unit_properties.sv */
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_unit_properties (
    input logic                           clk,
    input logic                           reset,
    input logic                           valid_rn0,
    input rename_pkg::t_optype            dst_optype,
    input rename_pkg::t_gpr_id            dst_gpr,
    input rename_pkg::t_gpr_id            src1_gpr,
    input rename_pkg::t_gpr_id            src2_gpr,
    input logic                           stall_rn0,
    input logic                           valid_rn1,
    input logic                           pdst_valid_rn1,
    input logic                           free_en,
    input logic [$clog2(`RN_NUM_PREGS):0] free_count
);

    int assert_fails = 0;

    // Stalled op stays on the inputs until it is taken
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall_rn0 |=> (valid_rn0 && $stable({dst_optype, dst_gpr, src1_gpr, src2_gpr})))
        else begin
            assert_fails++;
            $error("stalled op was not held on the inputs");
        end

    // Without a release the list stays empty and the stall persists
    a_stall_persist: assert property (@(posedge clk) disable iff (reset)
        (stall_rn0 && !free_en) |=> stall_rn0)
        else begin
            assert_fails++;
            $error("stall_rn0 dropped with no release into the empty free list");
        end

    a_release_not_full: assert property (@(posedge clk) disable iff (reset)
        free_en |-> (free_count < `RN_NUM_PREGS))
        else begin
            assert_fails++;
            $error("release into a full free list");
        end

    // x0 never takes a physical register
    a_x0_no_pdst: assert property (@(posedge clk) disable iff (reset)
        (valid_rn0 && !stall_rn0 && dst_gpr == '0) |=> (valid_rn1 && !pdst_valid_rn1))
        else begin
            assert_fails++;
            $error("destination x0 came out of rename with a physical register");
        end

endmodule

bind rename_unit rename_unit_properties props_i (
    .clk            ( clk                 ),
    .reset          ( reset               ),
    .valid_rn0      ( valid_rn0           ),
    .dst_optype     ( dst_optype          ),
    .dst_gpr        ( dst_gpr             ),
    .src1_gpr       ( src1_gpr            ),
    .src2_gpr       ( src2_gpr            ),
    .stall_rn0      ( stall_rn0           ),
    .valid_rn1      ( valid_rn1           ),
    .pdst_valid_rn1 ( pdst_valid_rn1      ),
    .free_en        ( free_en             ),
    .free_count     ( free_list_i.count_q )
);

/* bench/rename_unit_tb.sv */
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_unit_tb;

    // One table row holds a micro-op, optional writeback, read and release
    typedef struct {
        logic                valid;
        rename_pkg::t_optype optype;
        rename_pkg::t_gpr_id dst;
        rename_pkg::t_gpr_id src1;
        rename_pkg::t_gpr_id src2;
        logic                wr_en;
        rename_pkg::t_prf_id wr_pdst;
        logic                rd_en;
        rename_pkg::t_prf_id rd_psrc;
        logic                free_en;
        rename_pkg::t_prf_id free_pdst;
        logic                exp_stall;
    } t_step;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    valid_rn0;
    rename_pkg::t_optype     dst_optype;
    rename_pkg::t_gpr_id     dst_gpr;
    rename_pkg::t_gpr_id     src1_gpr;
    rename_pkg::t_gpr_id     src2_gpr;
    logic                    stall_rn0;
    logic                    valid_rn1;
    rename_pkg::t_prf_id     psrc1_rn1;
    rename_pkg::t_prf_id     psrc2_rn1;
    rename_pkg::t_prf_id     pdst_rn1;
    logic                    psrc1_pend_rn1;
    logic                    psrc2_pend_rn1;
    logic                    pdst_valid_rn1;
    logic                    wr_en_ro0;
    rename_pkg::t_prf_id     wr_pdst_ro0;
    rename_pkg::t_reg_data   wr_data_ro0;
    logic                    rd_en_rd0;
    rename_pkg::t_prf_id     rd_psrc_rd0;
    rename_pkg::t_reg_data   rd_data_rd1;
    logic                    free_en;
    rename_pkg::t_prf_id     free_pdst;

    t_step steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    // Reference model
    rename_pkg::t_prf_id   map_m  [`RN_NUM_GPRS];
    logic                  pend_m [`RN_NUM_PREGS];
    rename_pkg::t_reg_data data_m [`RN_NUM_PREGS];
    rename_pkg::t_prf_id   free_m [$];

    always #5 clk = ~clk;

    rename_unit dut_i (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_on_error($sformatf("Timeout: run did not end within %0d cycles", cycle_limit));
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_rename(input rename_pkg::t_rename_pkt got,
                                input rename_pkg::t_rename_pkt exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t: rename packet %h, expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t: stall_rn0 %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t: valid_rn1 %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_data(input rename_pkg::t_reg_data got,
                              input rename_pkg::t_reg_data exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %0t: rd_data_rd1 %h, expected %h",
                                    $time, got, exp));
        end
    endtask

    function automatic rename_pkg::t_rename_pkt dut_pkt();
        rename_pkg::t_rename_pkt p;
        p.psrc1      = psrc1_rn1;
        p.psrc2      = psrc2_rn1;
        p.psrc1_pend = psrc1_pend_rn1;
        p.psrc2_pend = psrc2_pend_rn1;
        p.pdst       = pdst_rn1;
        p.pdst_valid = pdst_valid_rn1;
        return p;
    endfunction

    task automatic add_op(input rename_pkg::t_optype optype, input int dst, input int src1,
                          input int src2, input logic exp_stall);
        t_step s;
        s.valid     = 1'b1;
        s.optype    = optype;
        s.dst       = rename_pkg::t_gpr_id'(dst);
        s.src1      = rename_pkg::t_gpr_id'(src1);
        s.src2      = rename_pkg::t_gpr_id'(src2);
        s.wr_en     = 1'b0;
        s.wr_pdst   = '0;
        s.rd_en     = 1'b0;
        s.rd_psrc   = '0;
        s.free_en   = 1'b0;
        s.free_pdst = '0;
        s.exp_stall = exp_stall;
        steps.push_back(s);
    endtask

    task automatic add_idle();
        add_op(rename_pkg::OP_NONE, 0, 0, 0, 1'b0);
        steps[steps.size()-1].valid = 1'b0;
    endtask

    task automatic with_wb(input int pdst);
        steps[steps.size()-1].wr_en   = 1'b1;
        steps[steps.size()-1].wr_pdst = rename_pkg::t_prf_id'(pdst);
    endtask

    task automatic with_rd(input int psrc);
        steps[steps.size()-1].rd_en   = 1'b1;
        steps[steps.size()-1].rd_psrc = rename_pkg::t_prf_id'(psrc);
    endtask

    task automatic with_free(input int pdst);
        steps[steps.size()-1].free_en   = 1'b1;
        steps[steps.size()-1].free_pdst = rename_pkg::t_prf_id'(pdst);
    endtask

    task automatic build_table();
        // Identity map and allocations from 32 upward
        add_op(rename_pkg::OP_REG, 1, 2, 3, 1'b0);
        add_op(rename_pkg::OP_REG, 2, 1, 0, 1'b0);
        // Writeback to 32 lands with the lookup of x1
        add_op(rename_pkg::OP_REG, 3, 1, 2, 1'b0);
        with_wb(32);
        // No allocation for OP_NONE, x0 and OP_IMM
        add_op(rename_pkg::OP_NONE, 5, 1, 3, 1'b0);
        with_rd(32);
        add_op(rename_pkg::OP_REG, 0, 2, 4, 1'b0);
        with_wb(33);
        add_op(rename_pkg::OP_IMM, 6, 2, 6, 1'b0);
        with_rd(33);
        // Drain the free list with each op reading the previous destination
        for (int k = 0; k < 29; k++) begin
            add_op(rename_pkg::OP_REG, 7 + k % 24, (k == 0) ? 3 : 7 + (k - 1) % 24, 1, 1'b0);
            with_wb(34 + k);
        end
        // Held op on an empty list goes through after a release
        add_op(rename_pkg::OP_REG, 31, 0, 0, 1'b1);
        with_wb(63);
        add_op(rename_pkg::OP_REG, 31, 0, 0, 1'b1);
        with_free(40);
        add_op(rename_pkg::OP_REG, 31, 0, 0, 1'b0);
        add_op(rename_pkg::OP_REG, 5, 31, 12, 1'b1);
        with_free(41);
        add_op(rename_pkg::OP_REG, 5, 31, 12, 1'b0);
        with_wb(40);
        // Read back with one read racing a write to the same entry
        add_idle();
        with_rd(34);
        add_idle();
        with_rd(63);
        add_idle();
        with_rd(40);
        add_idle();
        with_wb(45);
        with_rd(45);
        add_idle();
        with_rd(45);
        add_idle();
    endtask

    task automatic drive_step(input t_step s, input rename_pkg::t_reg_data wdata);
        valid_rn0   <= s.valid;
        dst_optype  <= s.optype;
        dst_gpr     <= s.dst;
        src1_gpr    <= s.src1;
        src2_gpr    <= s.src2;
        wr_en_ro0   <= s.wr_en;
        wr_pdst_ro0 <= s.wr_pdst;
        wr_data_ro0 <= wdata;
        rd_en_rd0   <= s.rd_en;
        rd_psrc_rd0 <= s.rd_psrc;
        free_en     <= s.free_en;
        free_pdst   <= s.free_pdst;
    endtask

    // Predicts this cycle's rename result, then applies the clock edge
    task automatic model_step(input t_step s, input rename_pkg::t_reg_data wdata,
                              output logic accept, output rename_pkg::t_rename_pkt pkt,
                              output rename_pkg::t_reg_data rdata);
        logic needs;
        needs          = (s.optype == rename_pkg::OP_REG) && (s.dst != '0);
        accept         = s.valid && !(needs && free_m.size() == 0);
        pkt.psrc1      = map_m[s.src1];
        pkt.psrc2      = map_m[s.src2];
        pkt.psrc1_pend = pend_m[pkt.psrc1] && !(s.wr_en && s.wr_pdst == pkt.psrc1);
        pkt.psrc2_pend = pend_m[pkt.psrc2] && !(s.wr_en && s.wr_pdst == pkt.psrc2);
        pkt.pdst_valid = needs;
        pkt.pdst       = (needs && free_m.size() != 0) ? free_m[0] : '0;
        rdata          = data_m[s.rd_psrc];
        if (s.wr_en) begin
            pend_m[s.wr_pdst] = 1'b0;
            data_m[s.wr_pdst] = wdata;
        end
        if (accept && needs) begin
            map_m[s.dst] = free_m.pop_front();
            pend_m[pkt.pdst] = 1'b1;
        end
        if (s.free_en) begin
            free_m.push_back(s.free_pdst);
        end
    endtask

    initial begin
        t_step                   row;
        rename_pkg::t_reg_data   wdata;
        rename_pkg::t_reg_data   rdata;
        rename_pkg::t_reg_data   prev_rdata;
        rename_pkg::t_rename_pkt pkt;
        rename_pkg::t_rename_pkt prev_pkt;
        logic                    accept;
        logic                    prev_accept;
        logic                    prev_rd;

        void'($urandom(32'h8553_07e8));
        build_table();
        cycle_limit = steps.size() * 4 + 50;

        for (int i = 0; i < `RN_NUM_GPRS; i++) begin
            map_m[i] = rename_pkg::t_prf_id'(i);
        end
        for (int i = 0; i < `RN_NUM_PREGS; i++) begin
            pend_m[i] = 1'b0;
            data_m[i] = '0;
        end
        for (int i = `RN_NUM_GPRS; i < `RN_NUM_PREGS; i++) begin
            free_m.push_back(rename_pkg::t_prf_id'(i));
        end

        reset <= 1'b1;
        drive_step(steps[steps.size()-1], '0);
        prev_accept = 1'b0;
        prev_rd     = 1'b0;
        prev_pkt    = '0;
        prev_rdata  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        foreach (steps[i]) begin
            row   = steps[i];
            wdata = row.wr_en ? rename_pkg::t_reg_data'($urandom()) : '0;
            @(posedge clk);
            drive_step(row, wdata);
            @(negedge clk);
            // Results of the previous row are now in rn1 and rd1
            check_valid(valid_rn1, prev_accept);
            if (prev_accept) begin
                check_rename(dut_pkt(), prev_pkt);
            end
            if (prev_rd) begin
                check_data(rd_data_rd1, prev_rdata);
            end
            check_stall(stall_rn0, row.exp_stall);
            if (dut_i.props_i.assert_fails != 0) begin
                stop_on_error("A bound assertion on the DUT failed");
            end
            model_step(row, wdata, accept, pkt, rdata);
            prev_accept = accept;
            prev_pkt    = pkt;
            prev_rd     = row.rd_en;
            prev_rdata  = rdata;
        end

        if (dut_i.props_i.assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* common/map_lookup_if.sv */
`timescale 1ns/10ps

interface map_lookup_if;

    // Source lookup request
    rename_pkg::t_gpr_id src1_gpr;
    rename_pkg::t_gpr_id src2_gpr;

    // Destination update, applied at the accepting edge
    logic                alloc;
    rename_pkg::t_gpr_id dst_gpr;
    rename_pkg::t_prf_id new_pdst;

    // Lookup results from the current map
    rename_pkg::t_prf_id psrc1;
    rename_pkg::t_prf_id psrc2;
    logic                psrc1_pend;
    logic                psrc2_pend;

    modport stage (
        output src1_gpr, src2_gpr, alloc, dst_gpr, new_pdst,
        input  psrc1, psrc2, psrc1_pend, psrc2_pend
    );

    // Map side
    modport tbl (
        input  src1_gpr, src2_gpr, alloc, dst_gpr, new_pdst,
        output psrc1, psrc2, psrc1_pend, psrc2_pend
    );

endinterface

/* common/rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural integer registers including x0
`define RN_NUM_GPRS 32

// Physical registers shared by map and free list
`define RN_NUM_PREGS 64

// Register data width
`define RN_XLEN 32

`endif

/* common/rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

    // Register indices
    typedef logic [$clog2(`RN_NUM_GPRS)-1:0]  t_gpr_id;
    typedef logic [$clog2(`RN_NUM_PREGS)-1:0] t_prf_id;

    // Register payload
    typedef logic [`RN_XLEN-1:0] t_reg_data;

    // Kind of destination operand
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_REG  = 2'd1,
        OP_IMM  = 2'd2
    } t_optype;

    // Decoded micro-op fields seen by rename
    typedef struct packed {
        t_optype dst_optype;
        t_gpr_id dst_gpr;
        t_gpr_id src1_gpr;
        t_gpr_id src2_gpr;
    } t_uinstr;

    // Rename result carried into rn1
    typedef struct packed {
        t_prf_id psrc1;
        t_prf_id psrc2;
        logic    psrc1_pend;
        logic    psrc2_pend;
        t_prf_id pdst;
        logic    pdst_valid;
    } t_rename_pkt;

endpackage

/* hw/prf_data.sv */
`timescale 1ns/10ps

`include "rename_macros.svh"

module prf_data (
    input  logic                  clk,

    input  logic                  wr_en_ro0,
    input  rename_pkg::t_prf_id   wr_pdst_ro0,
    input  rename_pkg::t_reg_data wr_data_ro0,

    input  logic                  rd_en_rd0,
    input  rename_pkg::t_prf_id   rd_psrc_rd0,
    output rename_pkg::t_reg_data rd_data_rd1
);

    rename_pkg::t_reg_data mem_q [`RN_NUM_PREGS];

    // Writeback port
    always_ff @(posedge clk) begin
        if (wr_en_ro0) begin
            mem_q[wr_pdst_ro0] <= wr_data_ro0;
        end
    end

    // Read returns the old value on a same-cycle write to that entry
    always_ff @(posedge clk) begin
        if (rd_en_rd0) begin
            rd_data_rd1 <= mem_q[rd_psrc_rd0];
        end
    end

endmodule

/* hw/rename/free_list.sv */
`timescale 1ns/10ps

`include "rename_macros.svh"

module free_list (
    input  logic                clk,
    input  logic                reset,

    input  logic                alloc_req,
    output rename_pkg::t_prf_id alloc_pdst,
    output logic                empty,

    input  logic                free_en,
    input  rename_pkg::t_prf_id free_pdst
);

    localparam int PTR_W         = $clog2(`RN_NUM_PREGS);
    localparam int FREE_AT_RESET = `RN_NUM_PREGS - `RN_NUM_GPRS;

    rename_pkg::t_prf_id fifo_q [`RN_NUM_PREGS];
    logic [PTR_W-1:0]    head_q;
    logic [PTR_W-1:0]    tail_q;
    logic [PTR_W:0]      count_q;

    assign alloc_pdst = fifo_q[head_q];
    assign empty      = (count_q == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Registers not mapped at reset start out free in ascending order
            for (int i = 0; i < FREE_AT_RESET; i++) begin
                fifo_q[i] <= rename_pkg::t_prf_id'(i + `RN_NUM_GPRS);
            end
            head_q  <= '0;
            tail_q  <= PTR_W'(FREE_AT_RESET % `RN_NUM_PREGS);
            count_q <= (PTR_W+1)'(FREE_AT_RESET);
        end else begin
            if (free_en) begin
                fifo_q[tail_q] <= free_pdst;
                tail_q         <= tail_q + 1'b1;
            end
            if (alloc_req) begin
                head_q <= head_q + 1'b1;
            end
            // Pop and push together leave the count alone
            case ({alloc_req, free_en})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* hw/rename/map_table.sv */
`timescale 1ns/10ps

`include "rename_macros.svh"

module map_table (
    input  logic                clk,
    input  logic                reset,

    map_lookup_if.tbl           lookup,

    input  logic                wr_en_ro0,
    input  rename_pkg::t_prf_id wr_pdst_ro0
);

    rename_pkg::t_prf_id      map_q [`RN_NUM_GPRS];
    logic [`RN_NUM_PREGS-1:0] pend_q;

    logic wb_hit_src1;
    logic wb_hit_src2;

    // Architectural to physical map
    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map out of reset
            for (int i = 0; i < `RN_NUM_GPRS; i++) begin
                map_q[i] <= rename_pkg::t_prf_id'(i);
            end
        end else if (lookup.alloc) begin
            map_q[lookup.dst_gpr] <= lookup.new_pdst;
        end
    end

    // Pending bit per physical register
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= '0;
        end else begin
            if (wr_en_ro0) begin
                pend_q[wr_pdst_ro0] <= 1'b0;
            end
            // Allocated register waits for its writeback
            if (lookup.alloc) begin
                pend_q[lookup.new_pdst] <= 1'b1;
            end
        end
    end

    // Lookups see the current map without this cycle's update
    assign lookup.psrc1 = map_q[lookup.src1_gpr];
    assign lookup.psrc2 = map_q[lookup.src2_gpr];

    // Writeback landing this cycle already counts as ready
    assign wb_hit_src1 = wr_en_ro0 && (wr_pdst_ro0 == lookup.psrc1);
    assign wb_hit_src2 = wr_en_ro0 && (wr_pdst_ro0 == lookup.psrc2);

    assign lookup.psrc1_pend = pend_q[lookup.psrc1] & ~wb_hit_src1;
    assign lookup.psrc2_pend = pend_q[lookup.psrc2] & ~wb_hit_src2;

endmodule

/* hw/rename/rename.sv */
`timescale 1ns/10ps

module rename (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    valid_rn0,
    input  rename_pkg::t_uinstr     uinstr_rn0,

    output logic                    stall_rn0,

    map_lookup_if.stage             lookup,

    output logic                    alloc_req,
    input  rename_pkg::t_prf_id     alloc_pdst,
    input  logic                    empty,

    output logic                    valid_rn1,
    output rename_pkg::t_rename_pkt rename_rn1
);

    logic                    needs_reg_rn0;
    logic                    accept_rn0;
    rename_pkg::t_rename_pkt rename_rn0;

    // Only integer destinations other than x0 take a new register
    assign needs_reg_rn0 = (uinstr_rn0.dst_optype == rename_pkg::OP_REG) &&
                           (uinstr_rn0.dst_gpr != '0);

    assign stall_rn0  = valid_rn0 & needs_reg_rn0 & empty;
    assign accept_rn0 = valid_rn0 & ~stall_rn0;
    assign alloc_req  = accept_rn0 & needs_reg_rn0;

    // Map lookup and update
    assign lookup.src1_gpr = uinstr_rn0.src1_gpr;
    assign lookup.src2_gpr = uinstr_rn0.src2_gpr;
    assign lookup.alloc    = alloc_req;
    assign lookup.dst_gpr  = uinstr_rn0.dst_gpr;
    assign lookup.new_pdst = alloc_pdst;

    always_comb begin
        rename_rn0.psrc1      = lookup.psrc1;
        rename_rn0.psrc2      = lookup.psrc2;
        rename_rn0.psrc1_pend = lookup.psrc1_pend;
        rename_rn0.psrc2_pend = lookup.psrc2_pend;
        rename_rn0.pdst_valid = needs_reg_rn0;
        // No destination means pdst reads as zero
        rename_rn0.pdst       = needs_reg_rn0 ? alloc_pdst : '0;
    end

    // rn0 -> rn1
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rn1 <= 1'b0;
        end else begin
            valid_rn1 <= accept_rn0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rn0) begin
            rename_rn1 <= rename_rn0;
        end
    end

endmodule

/* hw/rename_unit.sv */
`timescale 1ns/10ps

module rename_unit (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  valid_rn0,
    input  rename_pkg::t_optype   dst_optype,
    input  rename_pkg::t_gpr_id   dst_gpr,
    input  rename_pkg::t_gpr_id   src1_gpr,
    input  rename_pkg::t_gpr_id   src2_gpr,
    output logic                  stall_rn0,

    output logic                  valid_rn1,
    output rename_pkg::t_prf_id   psrc1_rn1,
    output rename_pkg::t_prf_id   psrc2_rn1,
    output rename_pkg::t_prf_id   pdst_rn1,
    output logic                  psrc1_pend_rn1,
    output logic                  psrc2_pend_rn1,
    output logic                  pdst_valid_rn1,

    input  logic                  wr_en_ro0,
    input  rename_pkg::t_prf_id   wr_pdst_ro0,
    input  rename_pkg::t_reg_data wr_data_ro0,

    input  logic                  rd_en_rd0,
    input  rename_pkg::t_prf_id   rd_psrc_rd0,
    output rename_pkg::t_reg_data rd_data_rd1,

    input  logic                  free_en,
    input  rename_pkg::t_prf_id   free_pdst
);

    rename_pkg::t_uinstr     uinstr_rn0;
    rename_pkg::t_rename_pkt rename_rn1;
    logic                    alloc_req;
    rename_pkg::t_prf_id     alloc_pdst;
    logic                    empty;

    map_lookup_if lookup_if ();

    // Pack micro-op
    assign uinstr_rn0.dst_optype = dst_optype;
    assign uinstr_rn0.dst_gpr    = dst_gpr;
    assign uinstr_rn0.src1_gpr   = src1_gpr;
    assign uinstr_rn0.src2_gpr   = src2_gpr;

    // Unpack rename result
    assign psrc1_rn1      = rename_rn1.psrc1;
    assign psrc2_rn1      = rename_rn1.psrc2;
    assign psrc1_pend_rn1 = rename_rn1.psrc1_pend;
    assign psrc2_pend_rn1 = rename_rn1.psrc2_pend;
    assign pdst_rn1       = rename_rn1.pdst;
    assign pdst_valid_rn1 = rename_rn1.pdst_valid;

    rename rename_i (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .valid_rn0  ( valid_rn0  ),
        .uinstr_rn0 ( uinstr_rn0 ),
        .stall_rn0  ( stall_rn0  ),
        .lookup     ( lookup_if  ),
        .alloc_req  ( alloc_req  ),
        .alloc_pdst ( alloc_pdst ),
        .empty      ( empty      ),
        .valid_rn1  ( valid_rn1  ),
        .rename_rn1 ( rename_rn1 )
    );

    map_table map_table_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .lookup      ( lookup_if   ),
        .wr_en_ro0   ( wr_en_ro0   ),
        .wr_pdst_ro0 ( wr_pdst_ro0 )
    );

    free_list free_list_i (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .alloc_req  ( alloc_req  ),
        .alloc_pdst ( alloc_pdst ),
        .empty      ( empty      ),
        .free_en    ( free_en    ),
        .free_pdst  ( free_pdst  )
    );

    prf_data prf_data_i (
        .clk         ( clk         ),
        .wr_en_ro0   ( wr_en_ro0   ),
        .wr_pdst_ro0 ( wr_pdst_ro0 ),
        .wr_data_ro0 ( wr_data_ro0 ),
        .rd_en_rd0   ( rd_en_rd0   ),
        .rd_psrc_rd0 ( rd_psrc_rd0 ),
        .rd_data_rd1 ( rd_data_rd1 )
    );

endmodule

/* rename_unit.f */
+incdir+common
common/rename_pkg.sv
common/map_lookup_if.sv
hw/rename/map_table.sv
hw/rename/free_list.sv
hw/rename/rename.sv
hw/prf_data.sv
hw/rename_unit.sv
bench/rename_unit_properties.sv
bench/rename_unit_tb.sv
